/* flist.f */
+incdir+.
link_pkg.sv
iomap_pkg.sv
link_if.sv
uart_tx_escaper.sv
uart_rx_unescaper.sv
cpu_io_port.sv
serial_link_top.sv
tb_serial_link.sv

/* Makefile */
# Verilator build and run for the UART link port testbench

VERILATOR ?= verilator
TOP       ?= tb_serial_link
OBJ_DIR   ?= obj_dir
FLIST     ?= flist.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(filter-out +%,$(shell cat $(FLIST)))
HDRS := tb_checks.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FLIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

/* tb_checks.svh */
// Compare tasks and the stop helper for the link port testbench.
// Included inside the testbench module, so WIDTH and the package types are in scope.

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ==================================================
// stop helper
// ==================================================

task automatic fail_stop(input string why);
  $display("%s", why);
  $display("Test failures found");
  $fatal(1);
endtask

// ==================================================
// compare tasks
// ==================================================

task automatic check_byte(input string name, input byte_t got, input byte_t exp);
  if (got !== exp)
    fail_stop($sformatf("FAILED %s got %02h expected %02h", name, got, exp));
endtask

task automatic check_word(input string name, input logic [WIDTH-1:0] got,
                          input logic [WIDTH-1:0] exp);
  if (got !== exp)
    fail_stop($sformatf("FAILED %s got %0h expected %0h", name, got, exp));
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp)
    fail_stop($sformatf("FAILED %s got %0h expected %0h", name, got, exp));
endtask

task automatic check_count(input string name, input int got, input int exp);
  if (got != exp)
    fail_stop($sformatf("FAILED %s got %0h expected %0h", name, got, exp));
endtask

`endif

/* tb_serial_link.sv */
// Testbench for the UART link port. A UART model logs transmit writes and
// feeds receive bytes, a table of rows covers the escape rules in both
// directions, and directed sections cover back-pressure, hold and counter.
// Inputs change on the falling edge, outputs are sampled mid low phase.

`timescale 1ns/1ps
`default_nettype none

module tb_serial_link import link_pkg::*, iomap_pkg::*;;

  localparam int WIDTH = 8;
  localparam int ROWS  = 5;
  localparam int LIMIT = 400 * ROWS + 600;       // cycle budget for the run

  typedef struct {
    byte_t tx;                                   // write byte
    logic  gaps;                                 // random ready gaps
    int    rx_n;                                 // raw receive bytes
    byte_t rx0;
    byte_t rx1;
    int    out_n;                                // expected UART writes
    byte_t out0;
    byte_t out1;
    int    exp_n;                                // expected CPU byte
    byte_t exp_b;
  } row_t;

  logic clk = 1'b0;
  logic arstn;
  logic i_io_rd, i_io_wr, i_u_ready, i_u_full, o_u_wr, o_u_rd, o_p_hold;
  logic o_cyclev, o_urxirq, o_utxirq;
  logic [14:0] i_mem_addr;
  logic [WIDTH-1:0] i_din, o_io_dout;
  byte_t o_u_dout, i_u_din;

  byte_t tx_log[$];                              // bytes seen on o_u_wr
  byte_t rx_q[$];                                // bytes the UART holds
  row_t  rows[ROWS];
  logic  rand_gaps = 1'b0;
  int    cycle_count = 0;
  int    rd_pulses = 0, rxirq_count = 0, txirq_count = 0;
  int    cyclev_at[$];                           // cycles of o_cyclev pulses

  `include "tb_checks.svh"

  serial_link_top #(.WIDTH(WIDTH)) u_dut (.*);

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= LIMIT)
      fail_stop("timeout: run exceeded its cycle limit");
  end

  // ==================================================
  // UART model, all on the falling edge
  // ==================================================

  always @(negedge clk) begin
    if (o_u_wr) tx_log.push_back(o_u_dout);
    if (o_u_rd) begin
      rd_pulses++;
      if (rx_q.size() != 0) void'(rx_q.pop_front());
    end
    if (o_urxirq) rxirq_count++;
    if (o_utxirq) txirq_count++;
    if (o_cyclev) cyclev_at.push_back(cycle_count);
    if (rand_gaps) i_u_ready = ($urandom_range(3) != 0);   // ready 3 of 4
    i_u_full = (rx_q.size() != 0);
    i_u_din  = (rx_q.size() != 0) ? rx_q[0] : 8'h00;
  end

  // ==================================================
  // CPU bus tasks
  // ==================================================

  task automatic io_read(input logic [14:0] addr, output logic [WIDTH-1:0] data);
    i_mem_addr = addr;
    i_io_rd    = 1'b1;
    #2 data = o_io_dout;                         // before the accepting edge
    @(negedge clk);
    i_io_rd = 1'b0;
  endtask

  task automatic io_write(input logic [14:0] addr, input logic [WIDTH-1:0] data);
    logic held;
    i_mem_addr = addr;
    i_din      = data;
    i_io_wr    = 1'b1;
    held       = 1'b1;
    while (held) begin
      #2 held = o_p_hold;
      @(negedge clk);
    end
    i_io_wr = 1'b0;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // ==================================================
  // one table row
  // ==================================================

  task automatic run_row(input int idx);
    row_t r;
    logic [WIDTH-1:0] rd;
    r = rows[idx];
    tx_log.delete();
    rand_gaps = r.gaps;
    if (!r.gaps) i_u_ready = 1'b1;
    io_write({11'd0, REG_RX_DATA}, WIDTH'(r.tx));
    if (r.rx_n > 0) rx_q.push_back(r.rx0);
    if (r.rx_n > 1) rx_q.push_back(r.rx1);
    while (tx_log.size() < r.out_n) @(negedge clk);          // escape pair done
    wait_cycles(12);
    check_count("tx_log.size", tx_log.size(), r.out_n);
    check_byte("o_u_dout first", tx_log[0], r.out0);
    if (r.out_n > 1) check_byte("o_u_dout second", tx_log[1], r.out1);
    if (r.exp_n > 0) begin
      rd = '0;
      while (!rd[0]) io_read({11'd0, REG_RX_FULL}, rd);    // poll full
      io_read({11'd0, REG_RX_DATA}, rd);
      check_byte("rx data", byte_t'(rd), r.exp_b);
    end else begin
      while (rx_q.size() != 0) @(negedge clk);
      wait_cycles(4);
    end
    io_read({11'd0, REG_RX_FULL}, rd);
    check_word("REG_RX_FULL", rd, '0);
    rand_gaps = 1'b0;
  endtask

  // ==================================================
  // main sequence
  // ==================================================

  initial begin
    logic [WIDTH-1:0] rd, c0, c1;
    int hold_cycles;
    void'($urandom(32'hf1cd6c91));
    arstn      = 1'b0;
    i_io_rd    = 1'b0;
    i_io_wr    = 1'b0;
    i_mem_addr = '0;
    i_din      = '0;
    i_u_ready  = 1'b1;
    i_u_full   = 1'b0;
    i_u_din    = '0;
    rows[0] = '{8'h41, 1'b0, 1, 8'h5a, 8'h00, 1, 8'h41, 8'h00, 1, 8'h5a};
    rows[1] = '{8'h10, 1'b1, 2, ESC_BYTE, {6'd0, 2'b11}, 2, ESC_BYTE, 8'h00, 1, 8'h13};
    rows[2] = '{8'h13, 1'b1, 2, {6'b000100, ESC_CODE_SKIP}, 8'h55, 2, ESC_BYTE, 8'h03, 0, 8'h00};
    rows[3] = '{8'h7e, 1'b0, 1, 8'h11, 8'h00, 1, 8'h7e, 8'h00, 0, 8'h00};
    rows[4] = '{8'h12, 1'b1, 2, {6'b000100, ESC_CODE_LITERAL}, 8'h01, 2, ESC_BYTE, 8'h02, 1, 8'h11};
    repeat (3) @(negedge clk);                   // 3 cycles in reset
    arstn = 1'b1;
    #2;
    check_bit("o_u_wr", o_u_wr, 1'b0);
    check_bit("o_u_rd", o_u_rd, 1'b0);
    check_bit("o_p_hold", o_p_hold, 1'b0);
    @(negedge clk);

    for (int i = 0; i < ROWS; i++) run_row(i);

    // back-pressure, second byte waits in the UART
    rd_pulses   = 0;
    rxirq_count = 0;
    rx_q.push_back(8'h21);
    rx_q.push_back(8'h22);
    while (rd_pulses < 1) @(negedge clk);
    wait_cycles(20);
    check_count("o_u_rd pulses", rd_pulses, 1);
    check_count("o_urxirq pulses", rxirq_count, 1);
    io_read({11'd0, REG_RX_DATA}, rd);
    check_byte("rx data", byte_t'(rd), 8'h21);
    rd = '0;
    while (!rd[0]) io_read({11'd0, REG_RX_FULL}, rd);
    io_read({11'd0, REG_RX_DATA}, rd);
    check_byte("rx data", byte_t'(rd), 8'h22);
    wait_cycles(3);
    check_count("o_u_rd pulses", rd_pulses, 2);
    check_count("o_urxirq pulses", rxirq_count, 2);

    // hold while the UART is not ready
    i_u_ready = 1'b0;
    wait_cycles(3);
    io_read({11'd0, REG_TX_BUSY}, rd);
    check_word("REG_TX_BUSY", rd, WIDTH'(1));
    tx_log.delete();
    txirq_count = 0;
    i_mem_addr  = {11'd0, REG_RX_DATA};
    i_din       = 8'h5c;
    i_io_wr     = 1'b1;
    for (hold_cycles = 0; hold_cycles < 6; hold_cycles++) begin
      #2 check_bit("o_p_hold", o_p_hold, 1'b1);
      @(negedge clk);
    end
    check_count("tx_log.size", tx_log.size(), 0);
    i_u_ready = 1'b1;
    #2 check_bit("o_p_hold", o_p_hold, 1'b0);    // write accepted now
    @(negedge clk);
    i_io_wr = 1'b0;
    while (tx_log.size() < 1) @(negedge clk);
    wait_cycles(10);
    check_count("tx_log.size", tx_log.size(), 1);
    check_byte("o_u_dout", tx_log[0], 8'h5c);
    if (txirq_count == 0) fail_stop("no o_utxirq pulse after transmit busy fell");

    // cycle counter and its carry pulse
    cyclev_at.delete();
    while (cyclev_at.size() < 2) @(negedge clk);
    check_count("o_cyclev spacing", cyclev_at[1] - cyclev_at[0], 256);
    io_read({11'd0, REG_CYCLES}, c0);
    wait_cycles(36);                             // reads end up 37 cycles apart
    io_read({11'd0, REG_CYCLES}, c1);
    check_word("REG_CYCLES", c1, WIDTH'(c0 + 37));
    io_read(15'h0020, rd);
    check_word("o_io_dout outside window", rd, '0);

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

/* serial_link_top.sv */
// Top level of the UART link port for a small stack CPU.
// CPU and UART signals are plain ports. Inside, one link interface
// joins the register block to the transmit and receive units.
// WIDTH sets the CPU word and cycle counter width.

`timescale 1ns/1ps
`default_nettype none

module serial_link_top import link_pkg::*; #(
  parameter int WIDTH = 24
) (
  input  wire              clk,
  input  wire              arstn,
  // CPU side
  input  logic             i_io_rd,
  input  logic             i_io_wr,
  input  logic [14:0]      i_mem_addr,
  input  logic [WIDTH-1:0] i_din,
  output logic [WIDTH-1:0] o_io_dout,
  output logic             o_p_hold,
  // UART side
  input  logic             i_u_ready,
  output logic             o_u_wr,
  output byte_t            o_u_dout,
  input  logic             i_u_full,
  input  byte_t            i_u_din,
  output logic             o_u_rd,
  // interrupts
  output logic             o_cyclev,
  output logic             o_urxirq,
  output logic             o_utxirq
);

  link_if u_link ();

  cpu_io_port #(.WIDTH(WIDTH)) u_io (
    .clk        (clk),
    .arstn      (arstn),
    .i_io_rd    (i_io_rd),
    .i_io_wr    (i_io_wr),
    .i_mem_addr (i_mem_addr),
    .i_din      (i_din),
    .o_io_dout  (o_io_dout),
    .o_p_hold   (o_p_hold),
    .link       (u_link.host),
    .o_cyclev   (o_cyclev),
    .o_urxirq   (o_urxirq),
    .o_utxirq   (o_utxirq)
  );

  uart_tx_escaper u_tx (
    .clk       (clk),
    .arstn     (arstn),
    .link      (u_link.tx),
    .i_u_ready (i_u_ready),
    .o_u_wr    (o_u_wr),
    .o_u_dout  (o_u_dout)
  );

  uart_rx_unescaper u_rx (
    .clk      (clk),
    .arstn    (arstn),
    .link     (u_link.rx),
    .i_u_full (i_u_full),
    .i_u_din  (i_u_din),
    .o_u_rd   (o_u_rd)
  );

endmodule

`default_nettype wire

/* cpu_io_port.sv */
// CPU register block of the link port.
// Decodes the 16-word I/O window, drives the read mux and the hold,
// turns writes of REG_RX_DATA into transmit strobes and reads of it
// into receive takes. Also runs the free-running cycle counter and
// makes the three interrupt pulses.

`timescale 1ns/1ps
`default_nettype none

module cpu_io_port import link_pkg::*, iomap_pkg::*; #(
  parameter int WIDTH = 24                       // CPU word and counter width
) (
  input  wire               clk,
  input  wire               arstn,
  input  logic              i_io_rd,             // I/O read strobe
  input  logic              i_io_wr,             // I/O write strobe
  input  logic [14:0]       i_mem_addr,
  input  logic [WIDTH-1:0]  i_din,
  output logic [WIDTH-1:0]  o_io_dout,
  output logic              o_p_hold,            // CPU wait state
  link_if.host              link,
  output logic              o_cyclev,            // counter wrapped
  output logic              o_urxirq,            // receive byte arrived
  output logic              o_utxirq             // transmit free again
);

  io_addr_t         reg_sel;                     // index inside window
  logic             internal;                    // address hits the window
  logic             wr_ok;                       // write accepted this cycle
  logic             rd_ok;                       // read accepted this cycle
  logic             tx_busy;
  logic             tx_busy_q;
  logic             rx_full_q;
  logic [WIDTH-1:0] out_word;                    // general purpose output
  logic [WIDTH-1:0] cycles;

  assign reg_sel  = io_addr_t'(i_mem_addr[3:0]);
  assign internal = (i_mem_addr < INTERNAL_LIMIT);
  assign wr_ok    = i_io_wr & internal & ~o_p_hold;
  assign rd_ok    = i_io_rd & internal & ~o_p_hold;

  // ==================================================
  // transmit and receive handshakes
  // ==================================================

  // own strobe counts until the escaper drops tx_ready
  assign tx_busy  = ~link.tx_ready | link.tx_stb;
  assign o_p_hold = i_io_wr & internal & (reg_sel == REG_RX_DATA) & tx_busy;

  assign link.rx_take = rd_ok & (reg_sel == REG_RX_DATA);
  assign link.tx_byte = byte_t'(out_word[7:0]);  // low byte of last write

  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn)
      link.tx_stb <= 1'b0;
    else
      link.tx_stb <= wr_ok & (reg_sel == REG_RX_DATA);
  end

  always_ff @(posedge clk) begin
    if (wr_ok && (reg_sel == REG_RX_DATA))
      out_word <= i_din;
  end

  // ==================================================
  // read mux
  // ==================================================

  always_comb begin
    if (!internal)
      o_io_dout = '0;                            // outside the window
    else begin
      case (reg_sel)
        REG_RX_DATA: o_io_dout = WIDTH'(link.rx_byte);
        REG_RX_FULL: o_io_dout = WIDTH'(link.rx_full);
        REG_TX_BUSY: o_io_dout = WIDTH'(tx_busy);
        REG_CYCLES:  o_io_dout = cycles;
        default:     o_io_dout = out_word;
      endcase
    end
  end

  // ==================================================
  // counter and interrupts
  // ==================================================

  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      {o_cyclev, cycles} <= '0;
      tx_busy_q <= 1'b0;
      rx_full_q <= 1'b0;
      o_urxirq  <= 1'b0;
      o_utxirq  <= 1'b0;
    end else begin
      {o_cyclev, cycles} <= {1'b0, cycles} + 1'b1;  // carry is the pulse
      tx_busy_q <= tx_busy;
      rx_full_q <= link.rx_full;
      o_urxirq  <= link.rx_full & ~rx_full_q;    // rising full
      o_utxirq  <= ~tx_busy & tx_busy_q;         // falling busy
    end
  end

  a_stb_when_ready: assert property (@(posedge clk) disable iff (!arstn)
    link.tx_stb |-> $past(link.tx_ready));

endmodule

`default_nettype wire

/* uart_rx_unescaper.sv */
// Receive side of the link. Raw UART bytes are read one at a time and
// decoded into the holding register that the CPU polls.
// Plain bytes pass unchanged, 10h, 0xh gives 10h+x, a 12h prefix drops
// itself and the byte after it, and a lone 11h or 13h is dropped.
// While the holding register is full, data bytes stay in the UART.
// Prefix and skipped bytes are read regardless.

`timescale 1ns/1ps
`default_nettype none

module uart_rx_unescaper import link_pkg::*; (
  input  wire   clk,
  input  wire   arstn,
  link_if.rx    link,
  input  logic  i_u_full,                        // UART holds a byte
  input  byte_t i_u_din,                         // that byte
  output logic  o_u_rd                           // one-cycle UART take
);

  rx_state_t state;                              // decoder state
  rx_state_t state_nxt;
  logic      rx_ok;                              // new raw byte to look at
  logic      in_span;                            // raw byte is 10h..13h
  logic      take;                               // read the raw byte
  logic      load;                               // write holding register
  byte_t     load_val;

  assign rx_ok   = i_u_full & ~o_u_rd;           // last take not seen yet
  assign in_span = (i_u_din[7:2] == ESC_SPAN_TAG);

  // ==================================================
  // decode
  // ==================================================

  always_comb begin
    state_nxt = state;
    take      = 1'b0;
    load      = 1'b0;
    load_val  = i_u_din;
    if (rx_ok) begin
      case (state)
        RX_IDLE: begin
          if (in_span) begin
            take = 1'b1;                         // prefix always consumed
            case (i_u_din[1:0])
              ESC_CODE_LITERAL: state_nxt = RX_LITERAL;
              ESC_CODE_SKIP:    state_nxt = RX_SKIP;
              default:          state_nxt = RX_IDLE;   // lone prefix
            endcase
          end else if (!link.rx_full) begin
            take = 1'b1;                         // plain data byte
            load = 1'b1;
          end
        end
        RX_LITERAL: begin
          if (!link.rx_full) begin
            take      = 1'b1;
            load      = 1'b1;
            load_val  = ESC_BYTE | byte_t'(i_u_din[1:0]);
            state_nxt = RX_IDLE;
          end
        end
        RX_SKIP: begin
          take      = 1'b1;                      // drop it
          state_nxt = RX_IDLE;
        end
        default: state_nxt = RX_IDLE;
      endcase
    end
  end

  // ==================================================
  // state and holding register
  // ==================================================

  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      state        <= RX_IDLE;
      o_u_rd       <= 1'b0;
      link.rx_full <= 1'b0;
    end else begin
      state  <= state_nxt;
      o_u_rd <= take;
      if (load)
        link.rx_full <= 1'b1;                    // load only when empty
      else if (link.rx_take)
        link.rx_full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load)
      link.rx_byte <= load_val;
  end

  a_rd_single: assert property (@(posedge clk) disable iff (!arstn)
    o_u_rd |=> !o_u_rd);

endmodule

`default_nettype wire

/* uart_tx_escaper.sv */
// Transmit side of the link. Each strobed byte becomes one UART write,
// registered one cycle after the strobe. A byte from 10h to 13h goes out
// as 10h, and its low two bits follow as a second write once the UART
// is ready again.

`timescale 1ns/1ps
`default_nettype none

module uart_tx_escaper import link_pkg::*; (
  input  wire   clk,
  input  wire   arstn,
  link_if.tx    link,
  input  logic  i_u_ready,                       // UART can take a byte
  output logic  o_u_wr,                          // one-cycle UART write
  output byte_t o_u_dout                         // write data
);

  logic       esc_pend;                          // second byte still owed
  logic [1:0] esc_low;                           // low bits of escaped byte
  logic       in_span;                           // strobed byte needs escaping
  logic       send_low;                          // second byte goes out now

  assign in_span  = (link.tx_byte[7:2] == ESC_SPAN_TAG);
  assign send_low = esc_pend & i_u_ready & ~o_u_wr;

  // busy while a pair is in flight or the UART is not ready
  assign link.tx_ready = i_u_ready & ~esc_pend & ~o_u_wr;

  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      esc_pend <= 1'b0;
      o_u_wr   <= 1'b0;
    end else begin
      o_u_wr <= 1'b0;                            // strobe by default
      if (link.tx_stb) begin
        o_u_wr <= 1'b1;
        if (in_span)
          esc_pend <= 1'b1;                      // low bits follow later
      end else if (send_low) begin
        o_u_wr   <= 1'b1;
        esc_pend <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (link.tx_stb) begin
      esc_low  <= link.tx_byte[1:0];
      o_u_dout <= in_span ? ESC_BYTE : link.tx_byte;
    end else if (send_low) begin
      o_u_dout <= byte_t'(esc_low);              // 00h..03h
    end
  end

  // a plain write commits two cycles back, when the host saw tx_ready
  a_wr_when_ready: assert property (@(posedge clk) disable iff (!arstn)
    $rose(o_u_wr) |-> ($past(link.tx_stb) ? $past(i_u_ready, 2) : $past(i_u_ready)));

endmodule

`default_nettype wire

/* link_if.sv */
// Byte channels between the CPU register block and the two link units.
// Transmit is a one-cycle strobe with no back-pressure, gated by tx_ready.
// Receive is a full flag that the host clears with a one-cycle take.

`timescale 1ns/1ps
`default_nettype none

interface link_if import link_pkg::*; ();

  // transmit channel
  logic  tx_stb;                                 // byte strobe from host
  byte_t tx_byte;                                // valid with tx_stb
  logic  tx_ready;                               // escaper can take a strobe

  // receive channel
  byte_t rx_byte;                                // decoded byte
  logic  rx_full;                                // rx_byte holds new data
  logic  rx_take;                                // host consumed rx_byte

  modport host (output tx_stb, tx_byte, rx_take,
                input  tx_ready, rx_byte, rx_full);

  modport tx   (input  tx_stb, tx_byte,
                output tx_ready);

  modport rx   (output rx_byte, rx_full,
                input  rx_take);

endinterface

`default_nettype wire

/* iomap_pkg.sv */
// CPU I/O register map of the link port.
// The port answers a 16-word window at the bottom of the I/O space.
// Addresses at or above INTERNAL_LIMIT read zero and ignore writes.

`default_nettype none

package iomap_pkg;

  typedef logic [3:0] io_addr_t;                 // index inside the window

  // ==================================================
  // register indices
  // ==================================================

  // read gives the byte and clears full, write sends a byte
  localparam io_addr_t REG_RX_DATA = 4'h0;
  localparam io_addr_t REG_RX_FULL = 4'h1;       // receive byte waiting
  localparam io_addr_t REG_TX_BUSY = 4'h2;       // transmit cannot take a write
  localparam io_addr_t REG_CYCLES  = 4'h6;       // free-running counter

  // first address past the window
  localparam int INTERNAL_LIMIT = 16;

endpackage

`default_nettype wire

/* link_pkg.sv */
// Byte-stuffing protocol definitions shared by the UART link units.
// A byte from 10h to 13h travels as the pair 10h, 0xh. Other prefixes
// in that span are control codes that the receiver swallows.
// Import with a wildcard in the header of any unit that needs them.

`default_nettype none

package link_pkg;

  // ==================================================
  // basic types
  // ==================================================

  typedef logic [7:0] byte_t;                    // one UART byte

  // ==================================================
  // escape encoding
  // ==================================================

  localparam byte_t      ESC_BYTE         = 8'h10;      // escape prefix
  localparam logic [5:0] ESC_SPAN_TAG     = 6'b000100;  // upper bits of 10h..13h
  localparam logic [1:0] ESC_CODE_LITERAL = 2'b00;      // 10h, 0xh pair
  localparam logic [1:0] ESC_CODE_SKIP    = 2'b10;      // next byte dropped

  // receive decoder states, 2 bits
  typedef enum logic [1:0] {
    RX_IDLE    = 2'd0,                           // expecting any byte
    RX_LITERAL = 2'd1,                           // second byte of a pair
    RX_SKIP    = 2'd2                            // byte to throw away
  } rx_state_t;

endpackage

`default_nettype wire
